/* mulIterative.sv */
// iterative multiplier working a quarter operand width per cycle, with sign fix-up
`timescale 1ns/10ps

module mulIterative #(
	parameter int WID = 64
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               headValid,
	input  mulPkg::mulReq_t    head,
	input  logic               spaceOk,
	output logic               take,
	output logic               mulDone,
	output mulPkg::mulResult_t result
);

	// digit width, four digits per operand
	localparam int QW = WID / 4;

	typedef enum logic [1:0] {
		IDLE,
		MULT,
		FIX
	} state_t;

	state_t state;
	logic [1:0] stepCnt;

	// operand selection and sign handling
	logic           signedOp;
	logic           immOp;
	logic [WID-1:0] opA;
	logic [WID-1:0] opB;
	logic           negA;
	logic           negB;

	// working registers
	logic [WID-1:0]      aa;
	logic [WID-1:0]      bb;
	logic [2*WID-1:0]    prod;
	logic                negR;
	mulPkg::tag_t        tagR;

	// one digit step
	logic [WID+QW-1:0] partial;
	logic [WID+QW-1:0] digitSum;
	logic [2*WID-1:0]  prodFix;

	// ==================================================
	// decode and sign adjust
	// ==================================================

	assign signedOp = (head.op == mulPkg::MUL) || (head.op == mulPkg::MULI);
	assign immOp    = (head.op == mulPkg::MULI) || (head.op == mulPkg::MULUI);

	// only the low WID bits of each operand take part
	assign opA = head.a[WID-1:0];
	assign opB = immOp ? head.imm[WID-1:0] : head.b[WID-1:0];

	// unsigned ops never see a negative operand
	assign negA = signedOp && opA[WID-1];
	assign negB = signedOp && opB[WID-1];

	// start only when idle, work is waiting and a result slot is reserved
	assign take = (state == IDLE) && headValid && spaceOk;

	// ==================================================
	// datapath
	// ==================================================

	// magnitude b times lowest digit of a, plus upper half of the running product
	assign partial  = (WID+QW)'(bb) * (WID+QW)'(aa[QW-1:0]);
	assign digitSum = partial + (WID+QW)'(prod[2*WID-1:WID]);

	// two's complement of the magnitude product when signs differ
	assign prodFix = negR ? -prod : prod;

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (take) begin
					// most negative value maps onto its own unsigned magnitude
					aa   <= negA ? -opA : opA;
					bb   <= negB ? -opB : opB;
					negR <= negA ^ negB;
					tagR <= head.tag;
					prod <= '0;
				end
			end
			MULT: begin
				// shift out one digit of a, sum goes in at the top of the product
				aa   <= aa >> QW;
				prod <= {digitSum, prod[WID-1:QW]};
			end
			FIX: begin
				// narrow units return the product zero-extended
				result.tag  <= tagR;
				result.prod <= mulPkg::prod_t'(prodFix);
			end
			default: begin
				prod <= prod;
			end
		endcase
	end

	// ==================================================
	// control FSM
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			stepCnt <= '0;
			mulDone <= 1'b0;
		end else begin
			mulDone <= 1'b0;
			case (state)
				IDLE: begin
					if (take) begin
						stepCnt <= '0;
						state   <= MULT;
					end
				end
				MULT: begin
					// four digit steps
					stepCnt <= stepCnt + 1'b1;
					if (stepCnt == 2'd3) begin
						state <= FIX;
					end
				end
				FIX: begin
					mulDone <= 1'b1;
					state   <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

/* mulPkg.sv */
// multiply unit shared types: operand, product, tag, operation code and the request/result structs

package mulPkg;

	// ==================================================
	// widths
	// ==================================================

	// operand width, also the default multiplier width
	localparam int WORD_W = 64;
	// destination register tag width
	localparam int TAG_W = 6;

	// ==================================================
	// plain vector types
	// ==================================================

	// one source operand or the immediate
	typedef logic [WORD_W-1:0] word_t;
	// full double-width product
	typedef logic [2*WORD_W-1:0] prod_t;
	// destination register tag
	typedef logic [TAG_W-1:0] tag_t;

	// operation code
	// signed ops: MUL, MULI
	// immediate ops: MULI, MULUI
	typedef enum logic [1:0] {
		MUL   = 2'd0,
		MULU  = 2'd1,
		MULI  = 2'd2,
		MULUI = 2'd3
	} mulOp_t;

	// ==================================================
	// structs
	// ==================================================

	// issued operation, 200 bits
	// narrower units carry operands zero-extended
	typedef struct packed {
		mulOp_t op;
		tag_t   tag;
		word_t  a;
		word_t  b;
		word_t  imm;
	} mulReq_t;

	// finished product with its tag, 134 bits
	typedef struct packed {
		tag_t  tag;
		prod_t prod;
	} mulResult_t;

endpackage

/* mulReqQueue.sv */
// request queue between issue and the multiplier, hands back one issue credit per freed entry
`timescale 1ns/10ps

module mulReqQueue #(
	parameter int DEPTH = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            reqValid,
	input  mulPkg::mulReq_t req,
	input  logic            take,
	output logic            headValid,
	output mulPkg::mulReq_t head,
	output logic            reqCredit
);

	// pointer and occupancy widths
	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

	// entry storage, payload only
	mulPkg::mulReq_t mem [DEPTH];

	logic [PW-1:0] wrPtr;
	logic [PW-1:0] rdPtr;
	logic [CW-1:0] count;
	logic          pop;

	// ==================================================
	// head and credit return
	// ==================================================

	assign headValid = (count != '0);
	assign head      = mem[rdPtr];

	// only a real pop frees a slot
	assign pop       = take && headValid;
	// credit goes back in the same cycle the slot frees
	assign reqCredit = pop;

	// ==================================================
	// storage write
	// ==================================================

	// issuer never writes without a credit, so no full check here
	always_ff @(posedge clk) begin
		if (reqValid) begin
			mem[wrPtr] <= req;
		end
	end

	// ==================================================
	// pointers and occupancy
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			// circular wrap at the last slot
			if (reqValid) begin
				wrPtr <= (wrPtr == LAST) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == LAST) ? '0 : rdPtr + 1'b1;
			end
			// push and pop together leave the count alone
			case ({reqValid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* mulResultBuf.sv */
// result buffer holding finished products until writeback credits let them go
`timescale 1ns/10ps

module mulResultBuf #(
	parameter int DEPTH       = 2,
	parameter int RES_CREDITS = 2
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               mulDone,
	input  mulPkg::mulResult_t result,
	input  logic               resCredit,
	output logic               spaceOk,
	output logic               resValid,
	output mulPkg::mulResult_t res
);

	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);
	localparam int KW = $clog2(RES_CREDITS + 1);
	localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

	// result storage, payload only
	mulPkg::mulResult_t mem [DEPTH];

	logic [PW-1:0] wrPtr;
	logic [PW-1:0] rdPtr;
	logic [CW-1:0] count;
	logic [KW-1:0] credits;

	// product arriving from the multiplier this cycle
	logic [CW:0] inFlight;
	logic [CW:0] committed;
	logic        pop;

	// ==================================================
	// space reservation for the multiplier
	// ==================================================

	// the multiplier holds at most one op, and it lands on mulDone
	assign inFlight  = (CW+1)'(mulDone);
	assign committed = (CW+1)'(count) + inFlight;
	// a free slot must remain after the arriving product
	assign spaceOk   = committed < (CW+1)'(DEPTH);

	// ==================================================
	// output, gated by writeback credits
	// ==================================================

	assign resValid = (count != '0) && (credits != '0);
	assign res      = mem[rdPtr];
	assign pop      = resValid;

	always_ff @(posedge clk) begin
		if (mulDone) begin
			mem[wrPtr] <= result;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			credits <= KW'(RES_CREDITS);
		end else begin
			if (mulDone) begin
				wrPtr <= (wrPtr == LAST) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == LAST) ? '0 : rdPtr + 1'b1;
			end
			case ({mulDone, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// spend on send, refill on return, both may happen together
			case ({pop, resCredit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

/* mulUnit.sv */
// integer multiply unit: request queue, iterative multiplier and result buffer with credit ports
`timescale 1ns/10ps

module mulUnit #(
	parameter int WID         = mulPkg::WORD_W,
	parameter int QUEUE_DEPTH = 4,
	parameter int RES_DEPTH   = 2,
	parameter int RES_CREDITS = 2
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               reqValid,
	input  mulPkg::mulReq_t    req,
	output logic               reqCredit,
	output logic               resValid,
	output mulPkg::mulResult_t res,
	input  logic               resCredit
);

	// ==================================================
	// internal links
	// ==================================================

	// queue head to multiplier
	logic               headValid;
	mulPkg::mulReq_t    head;
	logic               take;
	// multiplier to result buffer
	logic               spaceOk;
	logic               mulDone;
	mulPkg::mulResult_t mulRes;

	// issue side, frees one credit per take
	mulReqQueue #(
		.DEPTH (QUEUE_DEPTH)
	) i_queue (
		.clk       (clk),
		.rst       (rst),
		.reqValid  (reqValid),
		.req       (req),
		.take      (take),
		.headValid (headValid),
		.head      (head),
		.reqCredit (reqCredit)
	);

	// six cycles from take to mulDone
	mulIterative #(
		.WID (WID)
	) i_mul (
		.clk       (clk),
		.rst       (rst),
		.headValid (headValid),
		.head      (head),
		.spaceOk   (spaceOk),
		.take      (take),
		.mulDone   (mulDone),
		.result    (mulRes)
	);

	// in-order writeback, one result per credit
	mulResultBuf #(
		.DEPTH       (RES_DEPTH),
		.RES_CREDITS (RES_CREDITS)
	) i_resBuf (
		.clk       (clk),
		.rst       (rst),
		.mulDone   (mulDone),
		.result    (mulRes),
		.resCredit (resCredit),
		.spaceOk   (spaceOk),
		.resValid  (resValid),
		.res       (res)
	);

endmodule

/* run.sh */
#!/bin/sh
# builds the multiply unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tbMulUnit \
	-o tbMulUnit > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/tbMulUnit > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$SIM_LOG"; then
	exit 1
fi
exit 0

/* sim.f */
mulPkg.sv
mulReqQueue.sv
mulIterative.sv
mulResultBuf.sv
mulUnit.sv
tbMulUnit.sv

/* tbMulUnit.sv */
// testbench for the multiply unit, directed tests against issue and writeback credit models
`timescale 1ns/10ps

module tbMulUnit;

	localparam int QUEUE_DEPTH = 4;
	localparam int RES_DEPTH   = 2;
	localparam int RES_CREDITS = 2;
	// requests over all tests: 8 + 9 + 4 + 8 + 6
	localparam int TOTAL_REQS  = 35;
	localparam int CYCLE_LIMIT = 20 * TOTAL_REQS + 200;

	logic               clk = 1'b0;
	logic               rst;
	logic               reqValid;
	mulPkg::mulReq_t    req;
	logic               reqCredit;
	logic               resValid;
	mulPkg::mulResult_t res;
	logic               resCredit;

	// issuer and writeback credit models
	int issCredits;
	int wbCredits;
	bit autoCredit;

	// expected results in issue order
	mulPkg::mulResult_t expQ [$];
	mulPkg::tag_t       nextTag;
	string              curTest;
	int creditPulses;
	int rcvCount;
	int checkCount;
	int errCount;
	int testErrBase;
	int testCount;
	int cycleCnt = 0;

	mulUnit #(
		.WID         (mulPkg::WORD_W),
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.RES_DEPTH   (RES_DEPTH),
		.RES_CREDITS (RES_CREDITS)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.reqValid  (reqValid),
		.req       (req),
		.reqCredit (reqCredit),
		.resValid  (resValid),
		.res       (res),
		.resCredit (resCredit)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
	end

	// watchdog, ends a run that hangs
	initial begin
		wait (cycleCnt >= CYCLE_LIMIT);
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ==================================================
	// reference model and compare tasks
	// ==================================================

	// full product, second operand is imm for the immediate ops
	function automatic mulPkg::prod_t refProduct(input mulPkg::mulOp_t op,
			input mulPkg::word_t a, input mulPkg::word_t b, input mulPkg::word_t imm);
		mulPkg::word_t                     second;
		logic signed [2*mulPkg::WORD_W-1:0] sa;
		logic signed [2*mulPkg::WORD_W-1:0] sb;
		second = (op == mulPkg::MULI || op == mulPkg::MULUI) ? imm : b;
		if (op == mulPkg::MUL || op == mulPkg::MULI) begin
			sa = {{mulPkg::WORD_W{a[mulPkg::WORD_W-1]}}, a};
			sb = {{mulPkg::WORD_W{second[mulPkg::WORD_W-1]}}, second};
		end else begin
			sa = {{mulPkg::WORD_W{1'b0}}, a};
			sb = {{mulPkg::WORD_W{1'b0}}, second};
		end
		// low half of a double-width product is exact for both signednesses
		return mulPkg::prod_t'(sa * sb);
	endfunction

	function automatic mulPkg::word_t randWord();
		return {$urandom, $urandom};
	endfunction

	task automatic checkTag(input mulPkg::tag_t want, input mulPkg::tag_t got);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("ERR %s tag: expected %0d actual %0d", curTest, want, got);
		end
	endtask

	task automatic checkProd(input mulPkg::prod_t want, input mulPkg::prod_t got);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("ERR %s prod: expected %h actual %h", curTest, want, got);
		end
	endtask

	// ==================================================
	// cycle step: sample on the falling edge, then drive
	// ==================================================

	task automatic stepCycle();
		mulPkg::mulResult_t want;
		@(negedge clk);
		// outputs come from registers only, so they are settled here
		if (reqCredit) begin
			creditPulses++;
			issCredits++;
			if (issCredits > QUEUE_DEPTH) begin
				errCount++;
				$display("%s: issue credits rose above the queue depth", curTest);
			end
		end
		if (resValid) begin
			rcvCount++;
			if (wbCredits == 0) begin
				errCount++;
				$display("%s: a result went to writeback without a credit", curTest);
			end else begin
				wbCredits--;
			end
			if (expQ.size() == 0) begin
				errCount++;
				$display("%s: result with tag %0d arrived with nothing outstanding",
					curTest, res.tag);
			end else begin
				want = expQ.pop_front();
				checkTag(want.tag, res.tag);
				checkProd(want.prod, res.prod);
			end
		end
		reqValid  = 1'b0;
		resCredit = 1'b0;
		// open writeback hands each credit straight back
		if (autoCredit && resValid) begin
			resCredit = 1'b1;
			wbCredits++;
		end
	endtask

	// one request, issued once a queue credit is held
	task automatic sendOp(input mulPkg::mulOp_t op, input mulPkg::word_t a,
			input mulPkg::word_t b, input mulPkg::word_t imm);
		mulPkg::mulReq_t    r;
		mulPkg::mulResult_t e;
		while (issCredits == 0) begin
			stepCycle();
		end
		r.op   = op;
		r.tag  = nextTag;
		r.a    = a;
		r.b    = b;
		r.imm  = imm;
		e.tag  = nextTag;
		e.prod = refProduct(op, a, b, imm);
		expQ.push_back(e);
		req      = r;
		reqValid = 1'b1;
		issCredits--;
		nextTag++;
		stepCycle();
	endtask

	task automatic sendRandom();
		mulPkg::mulOp_t op;
		op = mulPkg::mulOp_t'(2'($urandom % 4));
		sendOp(op, randWord(), randWord(), randWord());
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0) begin
			stepCycle();
		end
	endtask

	task automatic startTest(input string name);
		curTest     = name;
		testErrBase = errCount;
		testCount++;
	endtask

	task automatic endTest();
		$display("test %s done, %0d errors", curTest, errCount - testErrBase);
	endtask

	// ==================================================
	// directed tests
	// ==================================================

	task automatic testReset();
		startTest("reset");
		repeat (8) begin
			stepCycle();
		end
		if (creditPulses != 0 || rcvCount != 0) begin
			errCount++;
			$display("reset: reqCredit or resValid pulsed before any request");
		end
		endTest();
	endtask

	task automatic testUnsigned();
		startTest("mulu");
		sendOp(mulPkg::MULU, '0, randWord(), randWord());
		sendOp(mulPkg::MULU, 64'd1, randWord(), '0);
		sendOp(mulPkg::MULU, randWord(), 64'd1, '0);
		sendOp(mulPkg::MULU, '1, '1, '0);
		repeat (4) begin
			sendOp(mulPkg::MULU, randWord(), randWord(), randWord());
		end
		waitDrain();
		endTest();
	endtask

	task automatic testSigned();
		mulPkg::word_t minInt;
		startTest("mul");
		minInt = {1'b1, {(mulPkg::WORD_W-1){1'b0}}};
		// all four sign combinations
		sendOp(mulPkg::MUL, 64'd123456789, 64'd987654321, '0);
		sendOp(mulPkg::MUL, 64'd123456789, -64'd987654321, '0);
		sendOp(mulPkg::MUL, -64'd123456789, 64'd987654321, '0);
		sendOp(mulPkg::MUL, -64'd123456789, -64'd987654321, '0);
		// magnitude of the most negative value needs the full width
		sendOp(mulPkg::MUL, minInt, '1, '0);
		sendOp(mulPkg::MUL, minInt, minInt, '0);
		repeat (3) begin
			sendOp(mulPkg::MUL, randWord(), randWord(), randWord());
		end
		waitDrain();
		endTest();
	endtask

	task automatic testImmediate();
		startTest("imm");
		// b holds junk that must not reach the product
		sendOp(mulPkg::MULI, randWord(), randWord() | 64'd1, -64'd3);
		sendOp(mulPkg::MULI, randWord(), randWord() | 64'd1, randWord());
		sendOp(mulPkg::MULUI, randWord(), randWord() | 64'd1, randWord());
		sendOp(mulPkg::MULUI, '1, randWord() | 64'd1, '1);
		waitDrain();
		endTest();
	endtask

	task automatic testBackToBack();
		int base;
		startTest("backToBack");
		base = creditPulses;
		repeat (8) begin
			sendRandom();
		end
		waitDrain();
		if (creditPulses - base != 8) begin
			errCount++;
			$display("backToBack: %0d reqCredit pulses for 8 requests", creditPulses - base);
		end
		if (issCredits != QUEUE_DEPTH) begin
			errCount++;
			$display("backToBack: issuer holds %0d credits after draining", issCredits);
		end
		endTest();
	endtask

	task automatic testStall();
		int base;
		startTest("stall");
		autoCredit = 1'b0;
		base = rcvCount;
		repeat (6) begin
			sendRandom();
		end
		// long enough for all six if writeback were open
		repeat (60) begin
			stepCycle();
		end
		if (rcvCount - base != RES_CREDITS) begin
			errCount++;
			$display("stall: %0d results left while credits were withheld", rcvCount - base);
		end
		// hand credits back one at a time
		for (int k = 1; k <= 4; k++) begin
			resCredit = 1'b1;
			wbCredits++;
			repeat (13) begin
				stepCycle();
			end
			if (rcvCount - base > RES_CREDITS + k) begin
				errCount++;
				$display("stall: one credit pulse released more than one result");
			end
		end
		waitDrain();
		endTest();
	endtask

	// ==================================================
	// main sequence
	// ==================================================

	initial begin
		void'($urandom(89));
		rst        = 1'b1;
		reqValid   = 1'b0;
		req        = '0;
		resCredit  = 1'b0;
		issCredits = QUEUE_DEPTH;
		wbCredits  = RES_CREDITS;
		autoCredit = 1'b1;
		nextTag    = '0;
		repeat (5) begin
			@(posedge clk);
		end
		@(negedge clk);
		rst = 1'b0;
		testReset();
		testUnsigned();
		testSigned();
		testImmediate();
		testBackToBack();
		testStall();
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
